// ==== Bender.yml ====
package:
  name: exe_stage

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/exe_pkg.sv
      - hdl/alu.sv
      - hdl/branch_unit.sv
      - div/div_ctrl.sv
      - div/div_count.sv
      - div/div_datapath.sv
      - hdl/exe.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/exe_chk.sv
      - bench/exe_tb.sv

// ==== bench/exe_chk.sv ====
module exe_chk import exe_pkg::*; (
    input logic      clk,
    input logic      rstn,
    input uop_t      uop,
    input wb_t       wb,
    input redirect_t redirect,
    input logic      stall
);

    stall_after_reset: assert property (@(posedge clk) !rstn |=> !stall)
        else $error("stall high right after reset");

    flush_needs_branch: assert property (@(posedge clk) disable iff (!rstn)
        redirect.flush |-> (uop.valid && uop.itype == ITYPE_BR))
        else $error("redirect flush without a valid branch micro-op");

    // unconditional kinds never fall through
    jump_always_flushes: assert property (@(posedge clk) disable iff (!rstn)
        (uop.valid && uop.itype == ITYPE_BR && uop.cond inside {JIRL, B, BL})
            |-> redirect.flush)
        else $error("unconditional branch without a redirect flush");

    no_write_r0: assert property (@(posedge clk) disable iff (!rstn)
        wb.valid |-> (wb.rd != '0))
        else $error("write-back to register 0");

    // divide latency bound
    stall_bounded: assert property (@(posedge clk) disable iff (!rstn)
        $rose(stall) |-> ##[1:34] !stall)
        else $error("stall held for more than 34 cycles");

endmodule

// ==== bench/exe_tb.sv ====
module exe_tb import exe_pkg::*; ();

    localparam int N_ALU      = 40;
    localparam int N_FWD      = 12;
    localparam int N_BR       = 36;
    localparam int N_DIV      = 12;
    localparam int N_CORNER   = 7;
    localparam int N_HOLD     = 4;
    localparam int N_UOPS     = N_ALU + N_FWD + N_BR + N_DIV + N_CORNER + N_HOLD;
    localparam int MAX_CYCLES = N_UOPS * 40;

    logic      clk;
    logic      rstn;
    uop_t      uop;
    word_t     src0;
    word_t     src1;
    wb_t       wb;
    redirect_t redirect;
    logic      stall;

    logic [31:0] lfsr;
    int          cycles;
    int          errors;
    int          checks;
    int          mark;

    // result register as the next micro-op will see it
    logic     fwd_valid;
    reg_idx_t fwd_rd;
    word_t    fwd_data;

    wb_t   exp_q[$];
    string name_q[$];

    br_cond_e conds [9] = '{JIRL, B, BL, BEQ, BNE, BLT, BGE, BLTU, BGEU};
    // equal, less, greater, then signed and unsigned disagree
    word_t    pa [4] = '{32'h0000_1234, 32'd3, 32'd9, 32'hffff_fffe};
    word_t    pb [4] = '{32'h0000_1234, 32'd9, 32'd3, 32'd5};

    exe exe_i (
        .clk      (clk),
        .rstn     (rstn),
        .uop      (uop),
        .src0     (src0),
        .src1     (src1),
        .wb       (wb),
        .redirect (redirect),
        .stall    (stall)
    );

    bind exe exe_chk chk_i (
        .clk      (clk),
        .rstn     (rstn),
        .uop      (uop),
        .wb       (wb),
        .redirect (redirect),
        .stall    (stall)
    );

    always #20 clk = !clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_word(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic taken_ref(input br_cond_e c, input word_t a, input word_t b);
        case (c)
            JIRL, B, BL: return 1'b1;
            BEQ:         return a == b;
            BNE:         return a != b;
            BLT:         return $signed(a) < $signed(b);
            BGE:         return $signed(a) >= $signed(b);
            BLTU:        return a < b;
            BGEU:        return a >= b;
            default:     return 1'b0;
        endcase
    endfunction

    function automatic wb_t ref_wb(input uop_t u, input word_t a, input word_t b);
        wb_t   r;
        word_t bb;
        word_t ma;
        word_t mb;
        word_t q;
        word_t m;
        logic  an;
        logic  bn;
        r.valid = 1'b0;
        r.rd    = u.rd;
        r.data  = '0;
        bb      = u.src2_imm ? u.imm : b;
        case (u.itype)
            ITYPE_ALU: begin
                r.valid = 1'b1;
                case (u.alu_op)
                    ADD:     r.data = a + bb;
                    SUB:     r.data = a - bb;
                    AND:     r.data = a & bb;
                    OR:      r.data = a | bb;
                    XOR:     r.data = a ^ bb;
                    NOR:     r.data = ~(a | bb);
                    SLL:     r.data = a << bb[4:0];
                    SRL:     r.data = a >> bb[4:0];
                    SRA:     r.data = $signed(a) >>> bb[4:0];
                    SLT:     r.data = {31'b0, $signed(a) < $signed(bb)};
                    SLTU:    r.data = {31'b0, a < bb};
                    LUI:     r.data = bb;
                    default: r.data = '0;
                endcase
            end
            ITYPE_BR: begin
                r.data  = u.pc + 32'd4;
                r.valid = (u.cond == BL) || (u.cond == JIRL);
                if (u.cond == BL) begin
                    r.rd = 5'd1;
                end
            end
            ITYPE_DIV: begin
                an = u.div_signed && a[31];
                bn = u.div_signed && b[31];
                ma = an ? -a : a;
                mb = bn ? -b : b;
                if (b == '0) begin
                    q = '1;
                    m = a;
                end else begin
                    q = ma / mb;
                    m = ma % mb;
                    if (an ^ bn) begin
                        q = -q;
                    end
                    if (an) begin
                        m = -m;
                    end
                end
                r.valid = 1'b1;
                r.data  = u.div_rem ? m : q;
            end
            default: r.valid = 1'b0;
        endcase
        r.valid = r.valid && u.valid && (r.rd != '0);
        return r;
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    // present one micro-op and hold it until the stage takes it
    task automatic issue(input string name, input uop_t u, input word_t s0, input word_t s1);
        word_t a;
        word_t b;
        wb_t   e;
        logic  tk;
        word_t tgt;
        a   = (fwd_valid && fwd_rd == u.rj) ? fwd_data : s0;
        b   = (fwd_valid && fwd_rd == u.rk) ? fwd_data : s1;
        e   = ref_wb(u, a, b);
        tk  = taken_ref(u.cond, a, b);
        tgt = (u.cond == JIRL) ? a + u.imm : u.pc + u.imm;
        @(negedge clk);
        uop  = u;
        src0 = s0;
        src1 = s1;
        #1;
        check({name, " stall"}, u.itype == ITYPE_DIV, stall);
        while (stall) begin
            @(negedge clk);
            #1;
        end
        check({name, " flush"}, (u.itype == ITYPE_BR) && tk, redirect.flush);
        if (u.itype == ITYPE_BR) begin
            check({name, " target"}, tgt, redirect.target);
        end
        if (e.valid) begin
            exp_q.push_back(e);
            name_q.push_back(name);
        end
        fwd_valid = e.valid;
        fwd_rd    = e.rd;
        fwd_data  = e.data;
    endtask

    task automatic idle();
        @(negedge clk);
        uop = '0;
        #1;
        fwd_valid = 1'b0;
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0) begin
            idle();
        end
        // a couple more cycles to catch a duplicate write
        idle();
        idle();
        if (errors == mark) begin
            $display("%-14s passed", name);
        end else begin
            $display("%-14s failed with %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    function automatic uop_t new_uop(input itype_e t, input reg_idx_t rd);
        uop_t u;
        u        = '0;
        u.valid  = 1'b1;
        u.itype  = t;
        u.rd     = rd;
        u.rj     = 5'd2;
        u.rk     = 5'd3;
        return u;
    endfunction

    always @(negedge clk) begin
        if (rstn && wb.valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected write-back to r%0d with data %h", wb.rd, wb.data);
            end else begin
                check(name_q.pop_front(), {exp_q[0].rd, exp_q[0].data}, {wb.rd, wb.data});
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        uop_t     u;
        reg_idx_t prev;
        clk       = 1'b0;
        rstn      = 1'b0;
        uop       = '0;
        src0      = '0;
        src1      = '0;
        lfsr      = 32'ha746a703;
        cycles    = 0;
        errors    = 0;
        checks    = 0;
        mark      = 0;
        fwd_valid = 1'b0;
        fwd_rd    = '0;
        fwd_data  = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        for (int i = 0; i < N_ALU; i++) begin
            u          = new_uop(ITYPE_ALU, reg_idx_t'(rand_word(5)));
            u.alu_op   = alu_op_e'(rand_word(4) % 12);
            u.src2_imm = logic'(rand_word(1));
            u.rj       = reg_idx_t'(rand_word(5));
            u.rk       = reg_idx_t'(rand_word(5));
            u.imm      = rand_word(32);
            issue("alu_random", u, rand_word(32), rand_word(32));
        end
        finish_test("alu_random");

        // each source names the previous destination while src inputs stay stale
        prev = 5'd3;
        for (int i = 0; i < N_FWD; i++) begin
            u        = new_uop(ITYPE_ALU, reg_idx_t'(i + 4));
            u.alu_op = alu_op_e'(rand_word(4) % 12);
            u.rj     = prev;
            u.rk     = (i % 2 == 1) ? prev : reg_idx_t'(20);
            issue("forward_chain", u, rand_word(32), rand_word(32));
            prev = u.rd;
        end
        finish_test("forward_chain");

        for (int c = 0; c < 9; c++) begin
            for (int p = 0; p < 4; p++) begin
                u      = new_uop(ITYPE_BR, 5'd4);
                u.cond = conds[c];
                u.imm  = rand_word(32) & 32'hffff_fffc;
                u.pc   = rand_word(32) & 32'hffff_fffc;
                issue("branch_all", u, pa[p], pb[p]);
            end
        end
        finish_test("branch_all");

        for (int i = 0; i < N_DIV; i++) begin
            u            = new_uop(ITYPE_DIV, reg_idx_t'(rand_word(5) % 31 + 1));
            u.div_signed = logic'(rand_word(1));
            u.div_rem    = logic'(rand_word(1));
            u.rj         = reg_idx_t'(rand_word(5));
            u.rk         = reg_idx_t'(rand_word(5));
            issue("div_random", u, rand_word(32), rand_word(32) >> rand_word(5));
        end
        finish_test("div_random");

        u = new_uop(ITYPE_DIV, 5'd9);
        issue("div_corner", u, 32'd1234, 32'd0);
        u.div_rem = 1'b1;
        issue("div_corner", u, 32'd1234, 32'd0);
        u.div_signed = 1'b1;
        issue("div_corner", u, -32'd7, 32'd0);
        u.div_rem = 1'b0;
        issue("div_corner", u, -32'd7, 32'd0);
        issue("div_corner", u, 32'h8000_0000, 32'hffff_ffff);
        u.div_rem = 1'b1;
        issue("div_corner", u, 32'h8000_0000, 32'hffff_ffff);
        u.rd = 5'd0;
        issue("div_corner", u, 32'd100, 32'd7);
        finish_test("div_corner");

        // the ALU op waits behind the divide and reads its result
        for (int i = 0; i < N_HOLD / 2; i++) begin
            u = new_uop(ITYPE_DIV, 5'd7);
            issue("stall_hold", u, rand_word(32), rand_word(32) >> 16);
            u    = new_uop(ITYPE_ALU, 5'd8);
            u.rj = 5'd7;
            issue("stall_hold", u, rand_word(32), rand_word(32));
        end
        finish_test("stall_hold");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== common/exe_defs.svh ====
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// datapath widths
`define EXE_XLEN        32
`define EXE_REG_BITS    5

// iterative divider
`define EXE_DIV_STEPS   32
`define EXE_STEP_BITS   6

// micro-op field widths
`define EXE_ITYPE_BITS  2
`define EXE_OP_BITS     4

// BL always links here
`define EXE_LINK_REG    1
`define EXE_PC_STEP     4

`endif

// ==== common/exe_pkg.sv ====
`include "exe_defs.svh"

package exe_pkg;

    typedef logic [`EXE_XLEN-1:0]      word_t;
    typedef logic [`EXE_REG_BITS-1:0]  reg_idx_t;
    typedef logic [`EXE_STEP_BITS-1:0] step_t;

    typedef enum logic [`EXE_ITYPE_BITS-1:0] {
        ITYPE_ALU = 2'd0,
        ITYPE_BR  = 2'd1,
        ITYPE_DIV = 2'd2
    } itype_e;

    typedef enum logic [`EXE_OP_BITS-1:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        NOR  = 4'd5,
        SLL  = 4'd6,
        SRL  = 4'd7,
        SRA  = 4'd8,
        SLT  = 4'd9,
        SLTU = 4'd10,
        LUI  = 4'd11
    } alu_op_e;

    // same codes as the decoder's cond field
    typedef enum logic [`EXE_OP_BITS-1:0] {
        JIRL = 4'b0011,
        B    = 4'b0100,
        BL   = 4'b0101,
        BEQ  = 4'b0110,
        BNE  = 4'b0111,
        BLT  = 4'b1000,
        BGE  = 4'b1001,
        BLTU = 4'b1010,
        BGEU = 4'b1011
    } br_cond_e;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } div_state_e;

    typedef struct packed {
        logic     valid;
        itype_e   itype;
        alu_op_e  alu_op;
        br_cond_e cond;
        logic     src2_imm;
        logic     div_rem;
        logic     div_signed;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        word_t    imm;
        word_t    pc;
    } uop_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic  flush;
        word_t target;
    } redirect_t;

endpackage

// ==== div/div_count.sv ====
`include "exe_defs.svh"

module div_count import exe_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  logic load,
    input  logic step,
    output logic last
);

    step_t cnt_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cnt_q <= '0;
        end else if (load) begin
            cnt_q <= step_t'(`EXE_DIV_STEPS);
        end else if (step) begin
            cnt_q <= cnt_q - step_t'(1);
        end
    end

    // one step left means this is the final one
    assign last = step && (cnt_q == step_t'(1));

endmodule

// ==== div/div_ctrl.sv ====
module div_ctrl import exe_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  logic start,
    input  logic last,
    output logic load,
    output logic step,
    output logic busy,
    output logic done
);

    div_state_e state_q;
    div_state_e state_d;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= DIV_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            DIV_IDLE: begin
                if (start) begin
                    state_d = DIV_RUN;
                end
            end
            DIV_RUN: begin
                if (last) begin
                    state_d = DIV_DONE;
                end
            end
            // result is valid for this one cycle
            DIV_DONE: state_d = DIV_IDLE;
            default:  state_d = DIV_IDLE;
        endcase
    end

    assign load = (state_q == DIV_IDLE) && start;
    assign step = state_q == DIV_RUN;
    assign busy = state_q == DIV_RUN;
    assign done = state_q == DIV_DONE;

endmodule

// ==== div/div_datapath.sv ====
`include "exe_defs.svh"

module div_datapath import exe_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  logic  load,
    input  logic  step,
    input  word_t dividend,
    input  word_t divisor,
    input  logic  is_signed,
    input  logic  want_rem,
    output word_t result
);

    word_t rem_q;
    word_t quo_q;
    word_t dsr_q;
    logic  qneg_q;
    logic  rneg_q;
    logic  rem_sel_q;
    logic  zero_q;

    word_t              a_mag;
    word_t              b_mag;
    word_t              q_fix;
    word_t              r_fix;
    logic [`EXE_XLEN:0] shifted;
    logic [`EXE_XLEN:0] diff;

    assign a_mag = (is_signed && dividend[`EXE_XLEN-1]) ? -dividend : dividend;
    assign b_mag = (is_signed && divisor[`EXE_XLEN-1]) ? -divisor : divisor;

    // quotient register doubles as the dividend shift source
    assign shifted = {rem_q, quo_q[`EXE_XLEN-1]};
    assign diff    = shifted - {1'b0, dsr_q};

    always_ff @(posedge clk) begin
        if (load) begin
            rem_q <= '0;
            quo_q <= a_mag;
            dsr_q <= b_mag;
        end else if (step) begin
            if (!diff[`EXE_XLEN]) begin
                rem_q <= diff[`EXE_XLEN-1:0];
                quo_q <= {quo_q[`EXE_XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[`EXE_XLEN-1:0];
                quo_q <= {quo_q[`EXE_XLEN-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            qneg_q    <= 1'b0;
            rneg_q    <= 1'b0;
            rem_sel_q <= 1'b0;
            zero_q    <= 1'b0;
        end else if (load) begin
            qneg_q    <= is_signed && (dividend[`EXE_XLEN-1] ^ divisor[`EXE_XLEN-1]);
            rneg_q    <= is_signed && dividend[`EXE_XLEN-1];
            rem_sel_q <= want_rem;
            zero_q    <= divisor == '0;
        end
    end

    // on divide by zero the remainder already ends up as the dividend
    assign q_fix  = zero_q ? '1 : (qneg_q ? -quo_q : quo_q);
    assign r_fix  = rneg_q ? -rem_q : rem_q;
    assign result = rem_sel_q ? r_fix : q_fix;

endmodule

// ==== hdl/alu.sv ====
module alu import exe_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        result = '0;
        unique case (op)
            ADD:  result = a + b;
            SUB:  result = a - b;
            AND:  result = a & b;
            OR:   result = a | b;
            XOR:  result = a ^ b;
            NOR:  result = ~(a | b);
            SLL:  result = a << shamt;
            SRL:  result = a >> shamt;
            SRA:  result = word_t'($signed(a) >>> shamt);
            SLT:  result = word_t'(lt_signed);
            SLTU: result = word_t'(lt_unsigned);
            // immediate is already shifted into place by decode
            LUI:  result = b;
            default: result = '0;
        endcase
    end

endmodule

// ==== hdl/branch_unit.sv ====
`include "exe_defs.svh"

module branch_unit import exe_pkg::*; (
    input  br_cond_e cond,
    input  word_t    a,
    input  word_t    b,
    input  word_t    pc,
    input  word_t    imm,
    output logic     taken,
    output word_t    target,
    output word_t    link
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = a == b;
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        taken = 1'b0;
        unique case (cond)
            JIRL, B, BL: taken = 1'b1;
            BEQ:         taken = eq;
            BNE:         taken = !eq;
            BLT:         taken = lt_s;
            BGE:         taken = !lt_s;
            BLTU:        taken = lt_u;
            BGEU:        taken = !lt_u;
            default:     taken = 1'b0;
        endcase
    end

    // register-indirect only for jirl
    assign target = (cond == JIRL) ? a + imm : pc + imm;
    assign link   = pc + word_t'(`EXE_PC_STEP);

endmodule

// ==== hdl/exe.sv ====
`include "exe_defs.svh"

module exe import exe_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  uop_t      uop,
    input  word_t     src0,
    input  word_t     src1,
    output wb_t       wb,
    output redirect_t redirect,
    output logic      stall
);

    word_t    opa;
    word_t    opb;
    word_t    alu_b;
    word_t    alu_res;
    word_t    br_target;
    word_t    br_link;
    word_t    div_res;
    logic     br_taken;
    logic     div_load;
    logic     div_step;
    logic     div_last;
    logic     div_busy;
    logic     div_done;
    logic     div_idle;
    logic     alu_fire;
    logic     br_fire;
    logic     div_start;
    reg_idx_t div_rd;

    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     nxt_wr;
    logic     nxt_valid;
    reg_idx_t nxt_rd;
    word_t    nxt_data;

    // bypass from the result register
    assign opa = (wb_valid && wb_rd != '0 && wb_rd == uop.rj) ? wb_data : src0;
    assign opb = (wb_valid && wb_rd != '0 && wb_rd == uop.rk) ? wb_data : src1;
    assign alu_b = uop.src2_imm ? uop.imm : opb;

    // held uop is ignored while the divider owns the stage
    assign div_idle  = !(div_busy || div_done);
    assign alu_fire  = uop.valid && (uop.itype == ITYPE_ALU) && div_idle;
    assign br_fire   = uop.valid && (uop.itype == ITYPE_BR) && div_idle;
    assign div_start = uop.valid && (uop.itype == ITYPE_DIV) && div_idle;

    alu u_alu (
        .op     (uop.alu_op),
        .a      (opa),
        .b      (alu_b),
        .result (alu_res)
    );

    branch_unit u_branch (
        .cond   (uop.cond),
        .a      (opa),
        .b      (opb),
        .pc     (uop.pc),
        .imm    (uop.imm),
        .taken  (br_taken),
        .target (br_target),
        .link   (br_link)
    );

    div_ctrl u_div_ctrl (
        .clk   (clk),
        .rstn  (rstn),
        .start (div_start),
        .last  (div_last),
        .load  (div_load),
        .step  (div_step),
        .busy  (div_busy),
        .done  (div_done)
    );

    div_count u_div_count (
        .clk  (clk),
        .rstn (rstn),
        .load (div_load),
        .step (div_step),
        .last (div_last)
    );

    div_datapath u_div_dp (
        .clk       (clk),
        .rstn      (rstn),
        .load      (div_load),
        .step      (div_step),
        .dividend  (opa),
        .divisor   (opb),
        .is_signed (uop.div_signed),
        .want_rem  (uop.div_rem),
        .result    (div_res)
    );

    always_ff @(posedge clk) begin
        if (div_load) begin
            div_rd <= uop.rd;
        end
    end

    always_comb begin
        nxt_wr   = 1'b0;
        nxt_rd   = uop.rd;
        nxt_data = alu_res;
        if (div_done) begin
            nxt_wr   = 1'b1;
            nxt_rd   = div_rd;
            nxt_data = div_res;
        end else if (alu_fire) begin
            nxt_wr = 1'b1;
        end else if (br_fire) begin
            nxt_wr   = (uop.cond == BL) || (uop.cond == JIRL);
            nxt_data = br_link;
            if (uop.cond == BL) begin
                nxt_rd = reg_idx_t'(`EXE_LINK_REG);
            end
        end
    end

    // r0 is never written
    assign nxt_valid = nxt_wr && (nxt_rd != '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= nxt_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (nxt_valid) begin
            wb_rd   <= nxt_rd;
            wb_data <= nxt_data;
        end
    end

    assign wb       = '{valid: wb_valid, rd: wb_rd, data: wb_data};
    assign redirect = '{flush: br_fire && br_taken, target: br_target};
    assign stall    = div_start || div_busy;

endmodule

// ==== sim.f ====
+incdir+common
common/exe_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
div/div_ctrl.sv
div/div_count.sv
div/div_datapath.sv
hdl/exe.sv
bench/exe_chk.sv
bench/exe_tb.sv
